// File: Bender.yml
package:
  name: fifo_credit

sources:
  - source/fifo_cfg_pkg.sv
  - source/fifo_ram_pkg.sv
  - source/fifo_push_ctrl_credit.sv
  - source/fifo_pop_ctrl.sv
  - source/fifo_ctrl_1r1w_push_credit.sv
  - source/fifo_ram_1r1w.sv
  - source/fifo_credit_top.sv
  - target: test
    files:
      - test/tb_fifo_credit.sv

// File: files.f
source/fifo_cfg_pkg.sv
source/fifo_ram_pkg.sv
source/fifo_push_ctrl_credit.sv
source/fifo_pop_ctrl.sv
source/fifo_ctrl_1r1w_push_credit.sv
source/fifo_ram_1r1w.sv
source/fifo_credit_top.sv
test/tb_fifo_credit.sv

// File: source/fifo_cfg_pkg.sv
/*
  FIFO configuration package
  Holds the geometry of the credit-flow FIFO and the vector types
  that carry entries, RAM addresses and counts, plus the status
  structs reported on the push and pop sides
*/
`default_nettype none

package fifo_cfg_pkg;

  // ------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------
  localparam int fifo_depth  = 8;
  localparam int data_width  = 16;
  localparam int addr_width  = $clog2(fifo_depth);
  localparam int count_width = $clog2(fifo_depth + 1);

  typedef logic [data_width-1:0]  data_t;
  typedef logic [addr_width-1:0]  addr_t;
  typedef logic [count_width-1:0] count_t;

  // Pointers wrap after the last RAM entry
  localparam addr_t  last_addr   = addr_t'(fifo_depth - 1);
  // The depth as a count, used to load counters at reset
  localparam count_t depth_count = count_t'(fifo_depth);

  // ------------------------------------------------------------
  // Status
  // ------------------------------------------------------------
  typedef struct packed {
    logic   full;
    logic   full_next;
    count_t slots;
    count_t slots_next;
  } push_status_t;

  typedef struct packed {
    logic   empty;
    logic   empty_next;
    count_t items;
    count_t items_next;
  } pop_status_t;

endpackage

`default_nettype wire

// File: source/fifo_credit_top.sv
/*
  Credit-flow FIFO top level
  The 1R1W FIFO controller with its flop RAM attached
*/
`timescale 1ns/10ps
`default_nettype none

module fifo_credit_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // Push side, driven by the credit sender
  input  logic                       push_credit_stall,
  output logic                       push_credit,
  input  logic                       push_valid,
  input  fifo_cfg_pkg::data_t        push_data,
  output fifo_cfg_pkg::count_t       push_credit_count,
  // Pop side
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output fifo_cfg_pkg::data_t        pop_data,
  // Status
  output fifo_cfg_pkg::push_status_t push_status,
  output fifo_cfg_pkg::pop_status_t  pop_status
);
  import fifo_ram_pkg::*;

  // RAM ports between controller and storage
  ram_wr_t     ram_wr;
  ram_rd_req_t ram_rd_req;
  ram_rd_rsp_t ram_rd_rsp;

  fifo_ctrl_1r1w_push_credit i_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .push_credit_count (push_credit_count),
    .pop_ready         (pop_ready),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .push_status       (push_status),
    .pop_status        (pop_status),
    .ram_wr            (ram_wr),
    .ram_rd_req        (ram_rd_req),
    .ram_rd_rsp        (ram_rd_rsp)
  );

  fifo_ram_1r1w i_ram (
    .clk        (clk),
    .ram_wr     (ram_wr),
    .ram_rd_req (ram_rd_req),
    .ram_rd_rsp (ram_rd_rsp)
  );

endmodule

`default_nettype wire

// File: source/fifo_ctrl_1r1w_push_credit.sv
/*
  FIFO controller, 1R1W with credit push and ready/valid pop
  Joins the push and pop controllers and exposes the ports of an
  external pseudo-dual-port RAM
*/
`timescale 1ns/10ps
`default_nettype none

module fifo_ctrl_1r1w_push_credit (
  input  logic                       clk,
  input  logic                       rst_n,
  // Push side
  input  logic                       push_credit_stall,
  output logic                       push_credit,
  input  logic                       push_valid,
  input  fifo_cfg_pkg::data_t        push_data,
  output fifo_cfg_pkg::count_t       push_credit_count,
  // Pop side
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output fifo_cfg_pkg::data_t        pop_data,
  // Status
  output fifo_cfg_pkg::push_status_t push_status,
  output fifo_cfg_pkg::pop_status_t  pop_status,
  // RAM ports
  output fifo_ram_pkg::ram_wr_t      ram_wr,
  output fifo_ram_pkg::ram_rd_req_t  ram_rd_req,
  input  fifo_ram_pkg::ram_rd_rsp_t  ram_rd_rsp
);
  import fifo_cfg_pkg::*;

  // Bypass hand-off between the two sides
  logic  bypass_ready;
  logic  bypass_valid;
  data_t bypass_data;

  // RAM traffic strobes, each side counts the other's moves
  logic  ram_push;
  logic  ram_pop;

  fifo_push_ctrl_credit i_push_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .bypass_ready      (bypass_ready),
    .ram_pop           (ram_pop),
    .push_credit       (push_credit),
    .push_credit_count (push_credit_count),
    .push_status       (push_status),
    .bypass_valid      (bypass_valid),
    .bypass_data       (bypass_data),
    .ram_wr            (ram_wr),
    .ram_push          (ram_push)
  );

  fifo_pop_ctrl i_pop_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop_ready    (pop_ready),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .ram_rd_rsp   (ram_rd_rsp),
    .ram_push     (ram_push),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .pop_status   (pop_status),
    .bypass_ready (bypass_ready),
    .ram_rd_req   (ram_rd_req),
    .ram_pop      (ram_pop)
  );

endmodule

`default_nettype wire

// File: source/fifo_pop_ctrl.sv
/*
  FIFO pop controller, ready/valid variant
  Tracks the items held in the RAM, reads the head entry and
  presents it on the pop side, or forwards the current push when
  the RAM holds nothing
*/
`timescale 1ns/10ps
`default_nettype none

module fifo_pop_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      pop_ready,
  input  logic                      bypass_valid,
  input  fifo_cfg_pkg::data_t       bypass_data,
  input  fifo_ram_pkg::ram_rd_rsp_t ram_rd_rsp,
  input  logic                      ram_push,
  output logic                      pop_valid,
  output fifo_cfg_pkg::data_t       pop_data,
  output fifo_cfg_pkg::pop_status_t pop_status,
  output logic                      bypass_ready,
  output fifo_ram_pkg::ram_rd_req_t ram_rd_req,
  output logic                      ram_pop
);
  import fifo_cfg_pkg::*;

  addr_t  rd_ptr;
  count_t items;
  count_t items_next;
  logic   empty;

  // The RAM is empty when no written entry is left
  assign empty = (items == '0);

  // ------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------

  // The head entry is requested whenever there is one
  assign ram_rd_req = '{valid: !empty, addr: rd_ptr};

  // With the RAM empty the pop side shows the push of this cycle
  // A push that is not taken lands in the RAM and stays at the head
  // so the shown data does not change until the transfer
  assign pop_valid = empty ? bypass_valid : ram_rd_rsp.valid;
  assign pop_data  = empty ? bypass_data : ram_rd_rsp.data;

  // The push side may hand over directly only if the pop side takes it now
  assign bypass_ready = empty && pop_ready;

  // A transfer from the RAM head
  assign ram_pop = !empty && ram_rd_rsp.valid && pop_ready;

  // Read pointer follows the write pointer around the ring
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (ram_pop) begin
      rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + addr_t'(1);
    end
  end

  // ------------------------------------------------------------
  // Item count
  // ------------------------------------------------------------

  // Writes become readable one cycle later, which the registered count
  // matches since it rises on the same edge as the RAM write
  always_comb begin
    case ({ram_push, ram_pop})
      2'b10:   items_next = items + count_t'(1);
      2'b01:   items_next = items - count_t'(1);
      default: items_next = items;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      items <= '0;
    end else begin
      items <= items_next;
    end
  end

  assign pop_status = '{
    empty:      empty,
    empty_next: (items_next == '0),
    items:      items,
    items_next: items_next
  };

endmodule

`default_nettype wire

// File: source/fifo_push_ctrl_credit.sv
/*
  FIFO push controller, credit/valid variant
  Returns credits to the sender, writes pushes into the RAM or hands
  them to the pop side when the FIFO is empty, and keeps the count
  of free RAM slots
*/
`timescale 1ns/10ps
`default_nettype none

module fifo_push_ctrl_credit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push_credit_stall,
  input  logic                       push_valid,
  input  fifo_cfg_pkg::data_t        push_data,
  input  logic                       bypass_ready,
  input  logic                       ram_pop,
  output logic                       push_credit,
  output fifo_cfg_pkg::count_t       push_credit_count,
  output fifo_cfg_pkg::push_status_t push_status,
  output logic                       bypass_valid,
  output fifo_cfg_pkg::data_t        bypass_data,
  output fifo_ram_pkg::ram_wr_t      ram_wr,
  output logic                       ram_push
);
  import fifo_cfg_pkg::*;

  logic   credit_en;
  count_t credit_cnt;
  count_t credit_cnt_next;
  logic   bypass_beat;
  logic   pop_beat;
  addr_t  wr_ptr;
  count_t slots;
  count_t slots_next;

  // ------------------------------------------------------------
  // Credit return
  // ------------------------------------------------------------

  // A push taken by the bypass leaves the FIFO in the same cycle
  assign bypass_beat = push_valid && bypass_ready;

  // Any pop frees a place, whether it came from the RAM or the bypass
  assign pop_beat = ram_pop || bypass_beat;

  // Credits go out one per cycle while some are owed and the sender does not stall
  assign push_credit = credit_en && (credit_cnt != '0) && !push_credit_stall;

  assign push_credit_count = credit_cnt;

  // The counter holds credits still owed to the sender
  // A pop in this cycle shows up in the count on the next cycle
  always_comb begin
    credit_cnt_next = credit_cnt;
    if (push_credit && !pop_beat) begin
      credit_cnt_next = credit_cnt - count_t'(1);
    end else if (pop_beat && !push_credit) begin
      credit_cnt_next = credit_cnt + count_t'(1);
    end
  end

  // The enable flag keeps credits quiet while reset is applied
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_en  <= 1'b0;
      credit_cnt <= depth_count;
    end else begin
      credit_en  <= 1'b1;
      credit_cnt <= credit_cnt_next;
    end
  end

  // ------------------------------------------------------------
  // Write path
  // ------------------------------------------------------------

  // Every push is offered to the pop side first
  assign bypass_valid = push_valid;
  assign bypass_data  = push_data;

  // Only a push the bypass did not take is written to the RAM
  assign ram_push = push_valid && !bypass_ready;

  assign ram_wr = '{valid: ram_push, addr: wr_ptr, data: push_data};

  // Write pointer wraps after the last entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (ram_push) begin
      wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + addr_t'(1);
    end
  end

  // ------------------------------------------------------------
  // Slot count
  // ------------------------------------------------------------

  // A bypassed push borrows a slot and gives it back in the same cycle
  // so only RAM traffic moves the count
  always_comb begin
    case ({ram_push, ram_pop})
      2'b10:   slots_next = slots - count_t'(1);
      2'b01:   slots_next = slots + count_t'(1);
      default: slots_next = slots;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slots <= depth_count;
    end else begin
      slots <= slots_next;
    end
  end

  assign push_status = '{
    full:       (slots == '0),
    full_next:  (slots_next == '0),
    slots:      slots,
    slots_next: slots_next
  };

endmodule

`default_nettype wire

// File: source/fifo_ram_1r1w.sv
/*
  Flop-based 1R1W RAM
  One write port with a latency of one cycle and one combinational
  read port
*/
`timescale 1ns/10ps
`default_nettype none

module fifo_ram_1r1w (
  input  logic                      clk,
  input  fifo_ram_pkg::ram_wr_t     ram_wr,
  input  fifo_ram_pkg::ram_rd_req_t ram_rd_req,
  output fifo_ram_pkg::ram_rd_rsp_t ram_rd_rsp
);
  import fifo_cfg_pkg::*;

  // Storage array, contents are only read after being written
  data_t mem [fifo_depth];

  // ------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // ------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------

  // The response comes back in the cycle of the request
  assign ram_rd_rsp = '{valid: ram_rd_req.valid, data: mem[ram_rd_req.addr]};

endmodule

`default_nettype wire

// File: source/fifo_ram_pkg.sv
/*
  FIFO RAM port package
  Port structs for the 1R1W pseudo-dual-port RAM behind the FIFO
  controller
*/
`default_nettype none

package fifo_ram_pkg;

  // Write port, the entry lands one cycle after valid
  typedef struct packed {
    logic                valid;
    fifo_cfg_pkg::addr_t addr;
    fifo_cfg_pkg::data_t data;
  } ram_wr_t;

  // Read request, served in the same cycle
  typedef struct packed {
    logic                valid;
    fifo_cfg_pkg::addr_t addr;
  } ram_rd_req_t;

  // Read response
  typedef struct packed {
    logic                valid;
    fifo_cfg_pkg::data_t data;
  } ram_rd_rsp_t;

endpackage

`default_nettype wire

// File: test/tb_fifo_credit.sv
/*
  Testbench for the credit-flow FIFO top level
  Plays the credit sender and the pop-side consumer, runs a table of
  phases and checks order, credit conservation, bypass and status
*/
`timescale 1ns/10ps
`default_nettype none

module tb_fifo_credit;
  import fifo_cfg_pkg::*;

  localparam int reset_cycles     = 10;
  localparam int phase_timeout    = 2000;
  localparam int min_phase_cycles = 16;
  localparam int num_phases       = 7;

  typedef enum logic [1:0] {stall_off, stall_on, stall_random} stall_mode_t;
  typedef enum logic [1:0] {ready_always, ready_never, ready_random} ready_mode_t;

  // One row per phase, the expected counts hold once the phase settles
  typedef struct packed {
    logic [7:0]  n_push;
    stall_mode_t stall;
    ready_mode_t ready;
    count_t      exp_items;
    count_t      exp_slots;
  } phase_t;

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------
  phase_t phases [num_phases] = '{
    '{8'd20, stall_off,    ready_always, count_t'(0),  depth_count},
    '{8'd8,  stall_off,    ready_never,  depth_count,  count_t'(0)},
    '{8'd0,  stall_off,    ready_random, count_t'(0),  depth_count},
    '{8'd40, stall_random, ready_random, count_t'(0),  depth_count},
    '{8'd0,  stall_on,     ready_always, count_t'(0),  depth_count},
    '{8'd8,  stall_off,    ready_never,  depth_count,  count_t'(0)},
    '{8'd60, stall_random, ready_random, count_t'(0),  depth_count}
  };

  logic         clk;
  logic         rst_n;
  logic         push_credit_stall;
  logic         push_credit;
  logic         push_valid;
  data_t        push_data;
  count_t       push_credit_count;
  logic         pop_ready;
  logic         pop_valid;
  data_t        pop_data;
  push_status_t push_status;
  pop_status_t  pop_status;

  // Sender model: credits held, credits still owed by the DUT, pushes in this phase
  int          held;
  int          owed;
  int          pushes_sent;
  data_t       expected_q [$];
  logic [31:0] lfsr_state;

  fifo_credit_top i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .push_credit_count (push_credit_count),
    .pop_ready         (pop_ready),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .push_status       (push_status),
    .pop_status        (pop_status)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Random bits and checks
  // ------------------------------------------------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic data_t random_word();
    data_t w;
    for (int i = 0; i < data_width; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_data(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_count(input count_t actual, input count_t expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------
  // Per-cycle observation, called at the falling edge
  // ------------------------------------------------------------
  task automatic observe_cycle();
    int   stored;
    int   next_stored;
    logic popped;
    // Entries in the queue before this cycle's push are the ones in the RAM
    stored = expected_q.size();
    check_flag(push_credit, (owed != 0) && !push_credit_stall, "push_credit");
    check_count(push_credit_count, count_t'(owed), "push_credit_count");
    // A push in flight has left the sender but is not counted by the DUT yet
    check_count(count_t'(held + int'(push_valid) + int'(push_credit_count) +
                int'(pop_status.items)), depth_count, "credits plus items");
    check_count(pop_status.items, count_t'(stored), "items");
    check_count(push_status.slots, count_t'(fifo_depth - stored), "slots");
    check_flag(pop_status.empty, stored == 0, "empty");
    check_flag(push_status.full, stored == fifo_depth, "full");
    if (push_valid) begin
      expected_q.push_back(push_data);
    end
    check_flag(pop_valid, expected_q.size() != 0, "pop_valid");
    // Empty FIFO with a willing consumer forwards the push in the same cycle
    if (stored == 0 && push_valid && pop_ready) begin
      check_data(pop_data, push_data, "bypass pop_data");
      check_count(pop_status.items_next, count_t'(0), "items_next on bypass");
    end
    popped = pop_valid && pop_ready;
    if (popped) begin
      check_data(pop_data, expected_q[0], "pop_data");
      void'(expected_q.pop_front());
    end
    // What is left after this cycle's push and pop is what the RAM holds next
    next_stored = expected_q.size();
    check_count(pop_status.items_next, count_t'(next_stored), "items_next");
    check_flag(pop_status.empty_next, next_stored == 0, "empty_next");
    check_count(push_status.slots_next, count_t'(fifo_depth - next_stored), "slots_next");
    check_flag(push_status.full_next, next_stored == fifo_depth, "full_next");
    // A credit seen now can be spent from the next cycle on
    if (push_credit) begin
      held++;
    end
    owed = owed - int'(push_credit) + int'(popped);
  endtask

  // Picks the inputs of the next cycle and drives them on the rising edge
  task automatic drive_next(input phase_t ph);
    logic  next_stall;
    logic  next_ready;
    logic  next_push;
    data_t next_data;
    case (ph.stall)
      stall_off: next_stall = 1'b0;
      stall_on:  next_stall = 1'b1;
      default:   next_stall = lfsr_bit();
    endcase
    case (ph.ready)
      ready_always: next_ready = 1'b1;
      ready_never:  next_ready = 1'b0;
      default:      next_ready = lfsr_bit();
    endcase
    next_push = 1'b0;
    next_data = push_data;
    if (pushes_sent < int'(ph.n_push) && held > 0) begin
      next_push = lfsr_bit();
    end
    if (next_push) begin
      next_data = random_word();
      held--;
      pushes_sent++;
    end
    @(posedge clk);
    push_credit_stall <= next_stall;
    pop_ready         <= next_ready;
    push_valid        <= next_push;
    push_data         <= next_data;
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int   cycles;
    logic done;
    rst_n             = 1'b0;
    push_credit_stall = 1'b0;
    push_valid        = 1'b0;
    push_data         = '0;
    pop_ready         = 1'b0;
    lfsr_state        = 32'h27437cbb;
    held              = 0;
    owed              = fifo_depth;
    pushes_sent       = 0;

    // Reset is sampled low on ten rising edges
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clk);
      if (i == reset_cycles - 1) begin
        rst_n <= 1'b1;
      end
      @(negedge clk);
      check_flag(push_credit, 1'b0, "push_credit in reset");
    end

    // First cycle after reset
    check_flag(pop_valid, 1'b0, "pop_valid after reset");
    check_flag(pop_status.empty, 1'b1, "empty after reset");
    check_count(pop_status.items, count_t'(0), "items after reset");
    check_count(push_status.slots, depth_count, "slots after reset");
    check_count(push_credit_count, depth_count, "push_credit_count after reset");

    for (int p = 0; p < num_phases; p++) begin
      pushes_sent = 0;
      cycles      = 0;
      done        = 1'b0;
      while (!done) begin
        if (cycles == phase_timeout) begin
          $display("Timeout: phase %0d did not settle within %0d cycles", p, phase_timeout);
          abort_run();
        end
        drive_next(phases[p]);
        @(negedge clk);
        observe_cycle();
        cycles++;
        done = (cycles >= min_phase_cycles) && (pushes_sent == int'(phases[p].n_push)) &&
               (count_t'(expected_q.size()) == phases[p].exp_items);
      end
      check_count(pop_status.items_next, phases[p].exp_items, "items at end of phase");
      check_count(push_status.slots_next, phases[p].exp_slots, "slots at end of phase");
      // A full FIFO owes no credit, so none may be sent
      if (phases[p].exp_slots == '0) begin
        check_flag(push_status.full_next, 1'b1, "full at end of phase");
        check_flag(push_credit, 1'b0, "push_credit while full");
        check_count(push_credit_count, count_t'(0), "push_credit_count while full");
      end
    end

    if (expected_q.size() != 0) begin
      $display("The scoreboard still holds %0d entries that never came out",
               expected_q.size());
      abort_run();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
